// ==== common/afifo_defs.svh ====
// Size constants shared by the asynchronous FIFO
// Address width, depth, data width, synchronizer length
// and pointer width with its extra wrap bit

`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// Log base two of the number of entries
`define AFIFO_LGFIFO 3

// Number of storage entries
`define AFIFO_DEPTH (1 << `AFIFO_LGFIFO)

// Data bits per entry
`define AFIFO_WIDTH 16

// Flops in each clock domain crossing, two at least
`define AFIFO_NFF 2

// Pointer carries one wrap bit above the memory index
`define AFIFO_PTR_W (`AFIFO_LGFIFO + 1)

`endif

// ==== common/afifo_pkg.sv ====
// Types shared by the asynchronous FIFO
// Data word type
// Pointer union, seen as a count or as wrap bit plus memory index

`include "afifo_defs.svh"

package afifo_pkg;

	// One FIFO data word
	typedef logic [`AFIFO_WIDTH-1:0] afifo_data_t;

	////////////////////////////////////////////////////////////////////////////
	// Pointer word
	////////////////////////////////////////////////////////////////////////////

	// Same bits, two views
	// Count view is what gets incremented and Gray encoded
	// Field view splits off the wrap bit from the memory index
	typedef union packed
	{
		logic [`AFIFO_PTR_W-1:0] count;
		struct packed
		{
			// Toggles each time the index wraps past the last entry
			logic wrap;
			// Entry selected in the storage array
			logic [`AFIFO_LGFIFO-1:0] idx;
		} fields;
	} afifo_ptr_u;

endpackage

// ==== dv/afifo_tb.sv ====
// Testbench for the asynchronous FIFO
// Galois LFSR stimulus and a reference queue model
// Reset, random traffic, full, stall hold and drain tests
// Watchdog sized from the number of words sent

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_tb
	import afifo_pkg::*;
();

	localparam int random_words = 200;
	localparam int total_words  = random_words + `AFIFO_DEPTH + 1;
	localparam int timeout_ns   = total_words * 40 * 100;
	localparam logic [31:0] lfsr_seed = 32'd66703;

	logic        gbl_clk;
	logic        i_wclk;
	logic        i_wr_reset_n;
	logic        i_rd_reset_n;
	logic        i_wr_valid;
	afifo_data_t i_wr_data;
	logic        o_wr_ready;
	logic        i_rd_ready;
	logic        o_rd_valid;
	afifo_data_t o_rd_data;

	logic [31:0] lfsr_state;
	// Words accepted by the DUT and not yet read back
	afifo_data_t model_q [$];
	logic        fill_done;
	int          accepted_count;
	int          hold_checks;
	int          failed_tests;
	int          err_cnt [5] = '{default: 0};
	string       test_names [5] = '{"reset_state", "random_order", "full_backpressure",
		"stall_hold", "drain_empty"};

	// Write clock starts 37 ns after the read clock so edges never line up
	tb_clk_gen #(.period_ns(100.0), .offset_ns(0.0)) rd_clk_gen (.o_clk(gbl_clk));
	tb_clk_gen #(.period_ns(100.0), .offset_ns(37.0)) wr_clk_gen (.o_clk(i_wclk));

	afifo_top afifo_top_i (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr_valid   (i_wr_valid),
		.i_wr_data    (i_wr_data),
		.o_wr_ready   (o_wr_ready),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd_ready   (i_rd_ready),
		.o_rd_valid   (o_rd_valid),
		.o_rd_data    (o_rd_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic afifo_data_t take_bits(input int n);
		afifo_data_t v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
			v = {v[`AFIFO_WIDTH-2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_eq(input int test_id, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %0s: expected 0x%0h actual 0x%0h", test_names[test_id],
				expected, actual);
			err_cnt[test_id]++;
		end
	endtask

	task automatic end_test(input int test_id);
		if (err_cnt[test_id] == 0)
			$display("test %0s: ok", test_names[test_id]);
		else
		begin
			$display("test %0s: %0d errors", test_names[test_id], err_cnt[test_id]);
			failed_tests++;
		end
	endtask

	// Write side drives random valid until random_words are in
	// or holds valid high until ready has stayed low for 16 cycles
	task automatic offer_words(input logic random_valid);
		int idle;
		idle = 0;
		accepted_count = 0;
		while (random_valid ? (accepted_count < random_words) : (idle < 16))
		begin
			@(negedge i_wclk);
			i_wr_valid = random_valid ? take_bits(1) : 1'b1;
			i_wr_data  = take_bits(`AFIFO_WIDTH);
			// Ready comes from write domain flops and is settled since the rising edge
			if (i_wr_valid && o_wr_ready)
			begin
				model_q.push_back(i_wr_data);
				accepted_count++;
				idle = 0;
			end
			else
				idle++;
		end
		@(negedge i_wclk);
		i_wr_valid = 1'b0;
		fill_done  = 1'b1;
	endtask

	// Read side handshake lands on the next rising edge
	task automatic take_words(input int test_id, input logic random_ready, input int count);
		int got;
		got = 0;
		while (got < count)
		begin
			@(negedge gbl_clk);
			i_rd_ready = random_ready ? take_bits(1) : 1'b1;
			if (o_rd_valid && i_rd_ready)
			begin
				if (model_q.size() == 0)
				begin
					$display("ERROR %0s: DUT gave a word that was never written",
						test_names[test_id]);
					err_cnt[test_id]++;
				end
				else
					check_eq(test_id, model_q.pop_front(), o_rd_data);
				got++;
			end
		end
		@(negedge gbl_clk);
		i_rd_ready = 1'b0;
	endtask

	// Once valid, the stalled output keeps the first word of the fill
	task automatic watch_stalled_output();
		logic seen_valid;
		seen_valid = 1'b0;
		while (!fill_done)
		begin
			@(negedge gbl_clk);
			if (seen_valid || o_rd_valid)
			begin
				check_eq(3, 1, o_rd_valid);
				check_eq(3, model_q[0], o_rd_data);
				hold_checks++;
			end
			seen_valid = seen_valid || o_rd_valid;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int waited;
		waited       = 0;
		lfsr_state   = lfsr_seed;
		i_wr_reset_n = 1'b0;
		i_rd_reset_n = 1'b0;
		i_wr_valid   = 1'b0;
		i_wr_data    = '0;
		i_rd_ready   = 1'b0;
		fill_done    = 1'b0;
		hold_checks  = 0;
		failed_tests = 0;
		repeat (8) @(posedge gbl_clk);
		@(negedge gbl_clk);
		i_rd_reset_n = 1'b1;
		@(negedge i_wclk);
		i_wr_reset_n = 1'b1;
		@(negedge gbl_clk);
		check_eq(0, 0, o_rd_valid);
		check_eq(0, 1, o_wr_ready);
		end_test(0);
		fork
			offer_words(1'b1);
			take_words(1, 1'b1, random_words);
		join
		// Every accepted word has been read, so no extra word may show up
		check_eq(1, 0, o_rd_valid);
		end_test(1);
		// Storage plus the output register fill up behind a stalled reader
		fill_done = 1'b0;
		fork
			offer_words(1'b0);
			watch_stalled_output();
		join
		check_eq(2, `AFIFO_DEPTH + 1, accepted_count);
		check_eq(2, 0, o_wr_ready);
		end_test(2);
		if (hold_checks == 0)
		begin
			$display("ERROR %0s: output never became valid during the stall", test_names[3]);
			err_cnt[3]++;
		end
		end_test(3);
		take_words(4, 1'b0, `AFIFO_DEPTH + 1);
		check_eq(4, 0, o_rd_valid);
		check_eq(4, 0, model_q.size());
		// Freed slots reach the write side through the synchronizer
		while (!o_wr_ready && waited < 20)
		begin
			@(negedge i_wclk);
			waited++;
		end
		check_eq(4, 1, o_wr_ready);
		end_test(4);
		$display("tests passed: %0d failed: %0d", 5 - failed_tests, failed_tests);
		if (failed_tests == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(timeout_ns);
		$display("timeout: tests did not finish within %0d ns", timeout_ns);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Free running clock source for the testbench
// Fixed period, start offset before the first rising edge

`timescale 1ns/1ps

module tb_clk_gen
#(
	parameter real period_ns = 100.0,
	parameter real offset_ns = 0.0
)
(
	output logic o_clk
);

	initial
	begin
		// Low until the offset has passed
		o_clk = 1'b0;
		#(offset_ns);
		forever
		begin
			#(period_ns / 2.0);
			o_clk = ~o_clk;
		end
	end

endmodule

// ==== hw/afifo/afifo_mem.sv ====
// Storage array of the asynchronous FIFO
// Write port clocked by the write clock
// Read port combinational from the read index

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_mem
	import afifo_pkg::*;
(
	input  logic                      i_wclk,
	input  logic                      i_we,
	input  logic [`AFIFO_LGFIFO-1:0]  i_widx,
	input  afifo_data_t               i_wdata,
	input  logic [`AFIFO_LGFIFO-1:0]  i_ridx,
	output afifo_data_t               o_rdata
);

	// AFIFO_DEPTH entries of one data word each
	afifo_data_t mem [`AFIFO_DEPTH];

	// Write side
	always_ff @(posedge i_wclk)
	begin
		if (i_we)
			mem[i_widx] <= i_wdata;
	end

	// Read side
	// Entry under the read index is stable once the reader sees it
	// through the synchronized write pointer
	assign o_rdata = mem[i_ridx];

endmodule

// ==== hw/afifo/afifo_rd_ctrl.sv ====
// Read side control of the asynchronous FIFO
// Binary read pointer and its Gray coded copy
// Empty detection against the synchronized write pointer
// Registered output stage with a valid/ready handshake

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_rd_ctrl
	import afifo_pkg::*;
(
	input  logic                      gbl_clk,
	input  logic                      i_rd_reset_n,
	input  logic                      i_rd_ready,
	output logic                      o_rd_valid,
	output afifo_data_t               o_rd_data,
	output logic [`AFIFO_LGFIFO-1:0]  o_mem_ridx,
	input  afifo_data_t               i_mem_rdata,
	output afifo_ptr_u                o_rgray,
	input  afifo_ptr_u                i_wgray_sync
);

	// Binary and Gray copies of the read pointer
	afifo_ptr_u rptr;
	afifo_ptr_u rgray;
	// Pointer value after the next word moves to the output register
	logic [`AFIFO_PTR_W-1:0] rptr_next;
	// Nothing left in storage as seen from this domain
	logic lcl_empty;
	// Output register can take a new word this cycle
	logic out_free;
	// Memory word moves into the output register
	logic rd_load;

	assign rptr_next = rptr.count + 1'b1;

	// Empty when both Gray pointers agree, wrap bit included
	assign lcl_empty = (i_wgray_sync.count == rgray.count);

	// Free when it holds nothing or its word leaves on this edge
	assign out_free = !o_rd_valid || i_rd_ready;
	assign rd_load  = out_free && !lcl_empty;

	////////////////////////////////////////////////////////////////////////////
	// Pointer and valid flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rptr       <= '0;
			rgray      <= '0;
			o_rd_valid <= 1'b0;
		end
		else
		begin
			if (rd_load)
			begin
				rptr.count  <= rptr_next;
				rgray.count <= rptr_next ^ (rptr_next >> 1);
			end
			// Valid holds while stalled
			// otherwise it follows whether storage had a word
			if (out_free)
				o_rd_valid <= !lcl_empty;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output data register
	////////////////////////////////////////////////////////////////////////////

	// Loads only together with a pointer advance, so a stalled word holds
	always_ff @(posedge gbl_clk)
	begin
		if (rd_load)
			o_rd_data <= i_mem_rdata;
	end

	// Memory read is combinational from the current index
	assign o_mem_ridx = rptr.fields.idx;

	// Gray copy goes back to the write domain
	assign o_rgray = rgray;

endmodule

// ==== hw/afifo/afifo_sync.sv ====
// Multi-flop synchronizer for a Gray coded pointer
// Chain of AFIFO_NFF registers cleared by reset

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_sync
	import afifo_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset_n,
	input  afifo_ptr_u i_gray,
	output afifo_ptr_u o_gray
);

	// Stage 0 samples the other domain, last stage is safe to use
	(* ASYNC_REG = "TRUE" *) afifo_ptr_u sync_q [`AFIFO_NFF];

	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
		begin
			for (int i = 0; i < `AFIFO_NFF; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			// Only one bit of a Gray pointer changes per step
			sync_q[0] <= i_gray;
			for (int i = 1; i < `AFIFO_NFF; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign o_gray = sync_q[`AFIFO_NFF-1];

endmodule

// ==== hw/afifo/afifo_top.sv ====
// Top level of the asynchronous FIFO
// Write control, read control, storage array
// Two pointer synchronizers, one per crossing direction
// Valid/ready handshakes on both the write and the read end

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_top
	import afifo_pkg::*;
(
	// Write domain
	input  logic        i_wclk,
	input  logic        i_wr_reset_n,
	input  logic        i_wr_valid,
	input  afifo_data_t i_wr_data,
	output logic        o_wr_ready,
	// Read domain
	input  logic        gbl_clk,
	input  logic        i_rd_reset_n,
	input  logic        i_rd_ready,
	output logic        o_rd_valid,
	output afifo_data_t o_rd_data
);

	// Memory ports
	logic                     mem_we;
	logic [`AFIFO_LGFIFO-1:0] mem_widx;
	logic [`AFIFO_LGFIFO-1:0] mem_ridx;
	afifo_data_t              mem_rdata;

	// Gray pointers before and after crossing
	afifo_ptr_u wgray;
	afifo_ptr_u wgray_sync;
	afifo_ptr_u rgray;
	afifo_ptr_u rgray_sync;

	////////////////////////////////////////////////////////////////////////////
	// Write domain
	////////////////////////////////////////////////////////////////////////////

	afifo_wr_ctrl u_wr_ctrl (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr_valid   (i_wr_valid),
		.o_wr_ready   (o_wr_ready),
		.o_mem_we     (mem_we),
		.o_mem_widx   (mem_widx),
		.o_wgray      (wgray),
		.i_rgray_sync (rgray_sync)
	);

	// Read pointer into the write domain
	afifo_sync u_sync_r2w (
		.i_clk     (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray    (rgray),
		.o_gray    (rgray_sync)
	);

	// Write data goes straight into storage
	afifo_mem u_mem (
		.i_wclk  (i_wclk),
		.i_we    (mem_we),
		.i_widx  (mem_widx),
		.i_wdata (i_wr_data),
		.i_ridx  (mem_ridx),
		.o_rdata (mem_rdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read domain
	////////////////////////////////////////////////////////////////////////////

	// Write pointer into the read domain
	afifo_sync u_sync_w2r (
		.i_clk     (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray    (wgray),
		.o_gray    (wgray_sync)
	);

	afifo_rd_ctrl u_rd_ctrl (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd_ready   (i_rd_ready),
		.o_rd_valid   (o_rd_valid),
		.o_rd_data    (o_rd_data),
		.o_mem_ridx   (mem_ridx),
		.i_mem_rdata  (mem_rdata),
		.o_rgray      (rgray),
		.i_wgray_sync (wgray_sync)
	);

endmodule

// ==== hw/afifo/afifo_wr_ctrl.sv ====
// Write side control of the asynchronous FIFO
// Binary write pointer and its Gray coded copy
// Full detection against the synchronized read pointer
// Memory write enable and write index

`timescale 1ns/1ps

`include "afifo_defs.svh"

module afifo_wr_ctrl
	import afifo_pkg::*;
(
	input  logic                      i_wclk,
	input  logic                      i_wr_reset_n,
	input  logic                      i_wr_valid,
	output logic                      o_wr_ready,
	output logic                      o_mem_we,
	output logic [`AFIFO_LGFIFO-1:0]  o_mem_widx,
	output afifo_ptr_u                o_wgray,
	input  afifo_ptr_u                i_rgray_sync
);

	// Binary and Gray copies of the write pointer
	afifo_ptr_u wptr;
	afifo_ptr_u wgray;
	// Pointer value after the next accepted word
	logic [`AFIFO_PTR_W-1:0] wptr_next;
	logic wr_full;
	logic wr_accept;

	assign wptr_next = wptr.count + 1'b1;

	// Full when the reader is exactly one lap behind
	// In Gray code that means the top two bits differ and the rest match
	assign wr_full = (i_rgray_sync.count ==
		{~wgray.count[`AFIFO_PTR_W-1 -: 2], wgray.count[`AFIFO_PTR_W-3:0]});

	assign o_wr_ready = !wr_full;
	// Handshake completes on this edge
	assign wr_accept = i_wr_valid && !wr_full;

	////////////////////////////////////////////////////////////////////////////
	// Pointer update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wptr  <= '0;
			wgray <= '0;
		end
		else if (wr_accept)
		begin
			wptr.count  <= wptr_next;
			// Gray copy tracks the new binary value
			wgray.count <= wptr_next ^ (wptr_next >> 1);
		end
	end

	// Memory write port, index field of the binary pointer
	assign o_mem_we   = wr_accept;
	assign o_mem_widx = wptr.fields.idx;

	// Only the Gray copy leaves this clock domain
	assign o_wgray = wgray;

endmodule

// ==== vlog.f ====
+incdir+common
common/afifo_pkg.sv
hw/afifo/afifo_wr_ctrl.sv
hw/afifo/afifo_rd_ctrl.sv
hw/afifo/afifo_sync.sv
hw/afifo/afifo_mem.sv
hw/afifo/afifo_top.sv
dv/tb_clk_gen.sv
dv/afifo_tb.sv
